//--- Bender.yml
package:
  name: rvv_alu_slice

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rvv_pkg.sv
      - rtl/rvv_alu_rs.sv
      - rtl/rvv_alu_unit.sv
      - rtl/rvv_alu.sv
      - rtl/rvv_rob_result_buf.sv
      - rtl/rvv_alu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/rvv_alu_tb.sv

//--- rtl/rvv_alu.sv
////////////////////////////////////////////////////////////
// rvv alu
// two alu units fed by the reservation station heads,
// in-order dual issue with results toward the rob
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rvv_alu (
  input  rvv_pkg::alu_rs_t  alu_uop0,
  input  rvv_pkg::alu_rs_t  alu_uop1,
  input  logic              fifo_empty,
  input  logic              fifo_1left_to_empty,
  output logic              pop0,
  output logic              pop1,
  output logic              result0_valid,
  output rvv_pkg::alu2rob_t result0,
  input  logic              result0_ready,
  output logic              result1_valid,
  output rvv_pkg::alu2rob_t result1,
  input  logic              result1_ready
);

  logic alu_uop0_valid;
  logic alu_uop1_valid;

  // head 1 is only valid when at least two entries are held
  assign alu_uop0_valid = !fifo_empty;
  assign alu_uop1_valid = !fifo_empty && !fifo_1left_to_empty;

  // pop exactly on a result transfer, uop1 only behind uop0
  assign pop0 = alu_uop0_valid && result0_valid && result0_ready;
  assign pop1 = pop0 && alu_uop1_valid && result1_valid && result1_ready;

  rvv_alu_unit u_alu_unit0 (
    .alu_uop_valid (alu_uop0_valid),
    .alu_uop       (alu_uop0),
    .result_valid  (result0_valid),
    .result        (result0)
  );

  rvv_alu_unit u_alu_unit1 (
    .alu_uop_valid (alu_uop1_valid),
    .alu_uop       (alu_uop1),
    .result_valid  (result1_valid),
    .result        (result1)
  );

  // a valid uop going in must come back out as a valid result
  always_comb begin
    if (alu_uop0_valid) begin
      a_unit0_result: assert final (result0_valid)
        else $error("alu unit 0 lost a uop, rob_entry %0d", alu_uop0.rob_entry);
    end
    if (alu_uop1_valid) begin
      a_unit1_result: assert final (result1_valid)
        else $error("alu unit 1 lost a uop, rob_entry %0d", alu_uop1.rob_entry);
    end
  end

endmodule

//--- rtl/rvv_alu_rs.sv
////////////////////////////////////////////////////////////
// rvv alu reservation station
// in-order fifo with one push port and two read heads,
// pops one or two oldest entries per cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rvv_consts.svh"

module rvv_alu_rs (
  input  logic              clk,
  input  logic              reset,
  input  logic              push_valid,
  input  rvv_pkg::alu_rs_t  push_uop,
  output logic              push_ready,
  output rvv_pkg::alu_rs_t  alu_uop0,
  output rvv_pkg::alu_rs_t  alu_uop1,
  output logic              fifo_empty,
  output logic              fifo_1left_to_empty,
  input  logic              pop0,
  input  logic              pop1
);

  import rvv_pkg::*;

  localparam int DEPTH = `RVV_RS_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  alu_rs_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_p1;
  logic [CNT_W-1:0] count;
  logic             push;
  logic [1:0]       pop_cnt;

  assign push_ready = (count != CNT_W'(DEPTH));
  assign push       = push_valid && push_ready;

  // pop1 only ever comes with pop0
  assign pop_cnt    = {1'b0, pop0} + {1'b0, pop1};

  // both heads read straight from storage
  assign rd_ptr_p1  = rd_ptr + PTR_W'(1);
  assign alu_uop0   = mem[rd_ptr];
  assign alu_uop1   = mem[rd_ptr_p1];

  assign fifo_empty          = (count == '0);
  assign fifo_1left_to_empty = (count == CNT_W'(1));

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_uop;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
      count  <= count + CNT_W'(push) - CNT_W'(pop_cnt);
    end
  end

  // pops come from rvv_alu and must match what is stored
  a_no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
    pop0 |-> !fifo_empty)
    else $error("pop0 while the station is empty");

  a_pop1_needs_pop0: assert property (@(posedge clk) disable iff (reset)
    pop1 |-> pop0)
    else $error("pop1 without pop0 breaks in-order issue");

  a_pop1_needs_two: assert property (@(posedge clk) disable iff (reset)
    pop1 |-> (count >= CNT_W'(2)))
    else $error("pop1 with fewer than two entries held");

endmodule

//--- rtl/rvv_alu_top.sv
////////////////////////////////////////////////////////////
// rvv alu slice top
// reservation station, dual alu and rob result buffer
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rvv_alu_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              push_valid,
  input  rvv_pkg::alu_rs_t  push_uop,
  output logic              push_ready,
  output logic              retire_valid,
  output rvv_pkg::alu2rob_t retire_data,
  input  logic              retire_ready
);

  import rvv_pkg::*;

  // station to alu
  alu_rs_t  alu_uop0;
  alu_rs_t  alu_uop1;
  logic     fifo_empty;
  logic     fifo_1left_to_empty;
  logic     pop0;
  logic     pop1;

  // alu to result buffer
  logic     result0_valid;
  alu2rob_t result0;
  logic     result0_ready;
  logic     result1_valid;
  alu2rob_t result1;
  logic     result1_ready;

  rvv_alu_rs u_alu_rs (
    .clk                 (clk),
    .reset               (reset),
    .push_valid          (push_valid),
    .push_uop            (push_uop),
    .push_ready          (push_ready),
    .alu_uop0            (alu_uop0),
    .alu_uop1            (alu_uop1),
    .fifo_empty          (fifo_empty),
    .fifo_1left_to_empty (fifo_1left_to_empty),
    .pop0                (pop0),
    .pop1                (pop1)
  );

  rvv_alu u_alu (
    .alu_uop0            (alu_uop0),
    .alu_uop1            (alu_uop1),
    .fifo_empty          (fifo_empty),
    .fifo_1left_to_empty (fifo_1left_to_empty),
    .pop0                (pop0),
    .pop1                (pop1),
    .result0_valid       (result0_valid),
    .result0             (result0),
    .result0_ready       (result0_ready),
    .result1_valid       (result1_valid),
    .result1             (result1),
    .result1_ready       (result1_ready)
  );

  rvv_rob_result_buf u_rob_result_buf (
    .clk                 (clk),
    .reset               (reset),
    .result0_valid       (result0_valid),
    .result0             (result0),
    .result0_ready       (result0_ready),
    .result1_valid       (result1_valid),
    .result1             (result1),
    .result1_ready       (result1_ready),
    .retire_valid        (retire_valid),
    .retire_data         (retire_data),
    .retire_ready        (retire_ready)
  );

endmodule

//--- rtl/rvv_alu_unit.sv
////////////////////////////////////////////////////////////
// rvv alu unit
// combinational per-element alu for one micro-op,
// sew 8, 16 or 32 over a 128-bit vector register
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rvv_consts.svh"

module rvv_alu_unit (
  input  logic              alu_uop_valid,
  input  rvv_pkg::alu_rs_t  alu_uop,
  output logic              result_valid,
  output rvv_pkg::alu2rob_t result
);

  import rvv_pkg::*;

  // one result per sew code, the lanes of each cover the whole register
  wire vreg_t lane_res [3];
  vreg_t      w_data;

  // operands arrive zero-extended to 32 bits, the caller keeps the low sew bits
  function automatic logic [31:0] lane_op(
    input alu_op_t     op,
    input sew_t        sew,
    input logic [31:0] a,
    input logic [31:0] b
  );
    logic [4:0]  shamt;
    logic [31:0] r;
    // shift amount modulo element width
    case (sew)
      `RVV_SEW8:  shamt = {2'b00, b[2:0]};
      `RVV_SEW16: shamt = {1'b0, b[3:0]};
      default:    shamt = b[4:0];
    endcase
    case (op)
      `RVV_OP_ADD:  r = a + b;
      `RVV_OP_SUB:  r = a - b;
      `RVV_OP_AND:  r = a & b;
      `RVV_OP_OR:   r = a | b;
      `RVV_OP_XOR:  r = a ^ b;
      `RVV_OP_MINU: r = (a < b) ? a : b;
      `RVV_OP_MAXU: r = (a < b) ? b : a;
      `RVV_OP_SLL:  r = a << shamt;
      default:      r = '0;
    endcase
    return r;
  endfunction

  // w = 0, 1, 2 gives 16, 8 or 4 lanes
  for (genvar w = 0; w < 3; w++) begin : g_sew
    localparam int EW = 8 << w;
    localparam int NL = `RVV_VLEN / EW;
    for (genvar l = 0; l < NL; l++) begin : g_lane
      logic [31:0] r;
      // vd = vs2 op vs1
      assign r = lane_op(alu_uop.opcode, sew_t'(w),
                         32'(alu_uop.vs2_data[l*EW +: EW]),
                         32'(alu_uop.vs1_data[l*EW +: EW]));
      // wraparound by truncation to the lane width
      assign lane_res[w][l*EW +: EW] = r[EW-1:0];
    end
  end

  always_comb begin
    case (alu_uop.sew)
      `RVV_SEW8:  w_data = lane_res[0];
      `RVV_SEW16: w_data = lane_res[1];
      `RVV_SEW32: w_data = lane_res[2];
      default:    w_data = '0;
    endcase
  end

  // all legal ops finish in this cycle
  assign result_valid     = alu_uop_valid;
  assign result.rob_entry = alu_uop.rob_entry;
  assign result.w_data    = w_data;

  // sew code 3 must never reach the alu
  always_comb begin
    if (alu_uop_valid) begin
      a_legal_sew: assert final (alu_uop.sew != 2'd3)
        else $error("reserved sew code 3, rob_entry %0d", alu_uop.rob_entry);
    end
  end

endmodule

//--- rtl/rvv_consts.svh
////////////////////////////////////////////////////////////
// rvv alu slice constants
// vector length, element width codes, opcodes, queue depths
////////////////////////////////////////////////////////////
`ifndef RVV_CONSTS_SVH
`define RVV_CONSTS_SVH

`define RVV_VLEN       128
`define RVV_ROB_IDX_W  4

// sew codes, code 3 is reserved
`define RVV_SEW8       2'd0
`define RVV_SEW16      2'd1
`define RVV_SEW32      2'd2

// queue depths, both powers of two
`define RVV_RS_DEPTH   8
`define RVV_RB_DEPTH   4

`define RVV_OP_ADD     3'd0
`define RVV_OP_SUB     3'd1
`define RVV_OP_AND     3'd2
`define RVV_OP_OR      3'd3
`define RVV_OP_XOR     3'd4
`define RVV_OP_MINU    3'd5
`define RVV_OP_MAXU    3'd6
`define RVV_OP_SLL     3'd7

`endif

//--- rtl/rvv_pkg.sv
////////////////////////////////////////////////////////////
// rvv alu slice types
// vector register, element width, rob index and opcode
// types, plus the micro-op and result structs
////////////////////////////////////////////////////////////
`include "rvv_consts.svh"

package rvv_pkg;

  // one whole vector register
  typedef logic [`RVV_VLEN-1:0] vreg_t;

  // element width code
  typedef logic [1:0] sew_t;

  typedef logic [`RVV_ROB_IDX_W-1:0] rob_idx_t;

  typedef logic [2:0] alu_op_t;

  // micro-op as issued into the alu reservation station
  typedef struct packed {
    rob_idx_t rob_entry;
    alu_op_t  opcode;
    sew_t     sew;
    vreg_t    vs1_data;
    vreg_t    vs2_data;
  } alu_rs_t;

  // alu result handed to the rob side
  typedef struct packed {
    rob_idx_t rob_entry;
    vreg_t    w_data;
  } alu2rob_t;

endpackage

//--- rtl/rvv_rob_result_buf.sv
////////////////////////////////////////////////////////////
// rvv rob result buffer
// in-order fifo taking up to two alu results per cycle,
// retires one per cycle through valid/ready
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rvv_consts.svh"

module rvv_rob_result_buf (
  input  logic              clk,
  input  logic              reset,
  input  logic              result0_valid,
  input  rvv_pkg::alu2rob_t result0,
  output logic              result0_ready,
  input  logic              result1_valid,
  input  rvv_pkg::alu2rob_t result1,
  output logic              result1_ready,
  output logic              retire_valid,
  output rvv_pkg::alu2rob_t retire_data,
  input  logic              retire_ready
);

  import rvv_pkg::*;

  localparam int DEPTH = `RVV_RB_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  alu2rob_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] free_cnt;
  logic             wr0;
  logic             wr1;
  logic             rd;

  // readiness comes only from free slots, never from retire_ready
  assign free_cnt      = CNT_W'(DEPTH) - count;
  assign result0_ready = (free_cnt >= CNT_W'(1));
  assign result1_ready = (free_cnt >= CNT_W'(2));

  assign wr0 = result0_valid && result0_ready;
  assign wr1 = result1_valid && result1_ready;

  assign retire_valid = (count != '0);
  assign retire_data  = mem[rd_ptr];
  assign rd           = retire_valid && retire_ready;

  // result0 is older and takes the first slot
  always_ff @(posedge clk) begin
    if (wr0) begin
      mem[wr_ptr] <= result0;
    end
    if (wr1) begin
      mem[wr_ptr + PTR_W'(1)] <= result1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(wr0) + PTR_W'(wr1);
      if (rd) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      count <= count + CNT_W'(wr0) + CNT_W'(wr1) - CNT_W'(rd);
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(DEPTH))
    else $error("result buffer written beyond capacity");

  // the alu side must never hand over result1 alone
  a_wr1_after_wr0: assert property (@(posedge clk) disable iff (reset)
    wr1 |-> wr0)
    else $error("result1 written without result0");

  a_retire_stable: assert property (@(posedge clk) disable iff (reset)
    (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire_data)))
    else $error("retire_data changed while stalled");

endmodule

//--- sources.f
+incdir+rtl
rtl/rvv_pkg.sv
rtl/rvv_alu_rs.sv
rtl/rvv_alu_unit.sv
rtl/rvv_alu.sv
rtl/rvv_rob_result_buf.sv
rtl/rvv_alu_top.sv
test/rvv_alu_tb.sv

//--- test/rvv_alu_tb.sv
////////////////////////////////////////////////////////////
// rvv alu slice testbench
// random micro-ops through station, alu pair and result
// buffer, retired results checked against a lane model
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "rvv_consts.svh"

module rvv_alu_tb;

  import rvv_pkg::*;

  logic       clk;
  logic       reset;
  logic       push_valid;
  alu_rs_t    push_uop;
  logic       push_ready;
  logic       retire_valid;
  alu2rob_t   retire_data;
  logic       retire_ready;

  int         seed = 32'hb87ef23c;
  alu2rob_t   exp_q [$];
  alu2rob_t   exp_head;
  logic       exp_avail;
  logic       push_taken;
  logic       lat_mode;
  logic [3:0] next_rob;
  int         n_pushed;
  int         n_retired;
  int         n_checks;
  int         n_fail;

  rvv_alu_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .push_valid   (push_valid),
    .push_uop     (push_uop),
    .push_ready   (push_ready),
    .retire_valid (retire_valid),
    .retire_data  (retire_data),
    .retire_ready (retire_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic bit roll(int pct);
    return (($random(seed) & 32'h7fffffff) % 100) < pct;
  endfunction

  function automatic alu_rs_t random_uop(logic [3:0] rob);
    alu_rs_t u;
    u.rob_entry = rob;
    u.opcode    = alu_op_t'($random(seed));
    u.sew       = sew_t'(($random(seed) & 32'h7fffffff) % 3);
    u.vs1_data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
    u.vs2_data  = {$random(seed), $random(seed), $random(seed), $random(seed)};
    return u;
  endfunction

  // vd = vs2 op vs1 per element with wraparound at the element width
  function automatic vreg_t expected_data(alu_rs_t u);
    int          ew;
    logic [31:0] mask;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    vreg_t       d;
    ew   = 8 << u.sew;
    mask = 32'hffff_ffff >> (32 - ew);
    d    = '0;
    for (int i = 0; i < `RVV_VLEN / ew; i++) begin
      a = 32'(u.vs2_data >> (i * ew)) & mask;
      b = 32'(u.vs1_data >> (i * ew)) & mask;
      case (u.opcode)
        `RVV_OP_ADD:  r = a + b;
        `RVV_OP_SUB:  r = a - b;
        `RVV_OP_AND:  r = a & b;
        `RVV_OP_OR:   r = a | b;
        `RVV_OP_XOR:  r = a ^ b;
        `RVV_OP_MINU: r = (b < a) ? b : a;
        `RVV_OP_MAXU: r = (b > a) ? b : a;
        default:      r = a << (b % ew);
      endcase
      d = d | (vreg_t'(r & mask) << (i * ew));
    end
    return d;
  endfunction

  // handshakes settle half a cycle before the edge that takes them
  always @(negedge clk) begin
    if (!reset) begin
      exp_avail = (exp_q.size() > 0);
      if (exp_avail) begin
        exp_head = exp_q[0];
      end
      if (retire_valid && retire_ready) begin
        n_retired++;
        n_checks++;
        if (exp_avail) begin
          void'(exp_q.pop_front());
        end
      end
      push_taken = push_valid && push_ready;
      if (push_taken) begin
        exp_q.push_back(alu2rob_t'{push_uop.rob_entry, expected_data(push_uop)});
        n_pushed++;
        next_rob++;
      end
    end
  end

  a_retire_value: assert property (@(posedge clk) disable iff (reset)
    (retire_valid && retire_ready) |-> (exp_avail && retire_data == exp_head))
    else begin
      n_fail++;
      if (!$sampled(exp_avail)) begin
        $display("retire at %0t with no micro-op outstanding", $time);
      end else begin
        $display("MISMATCH at %0t: rob %0d data %h, expected rob %0d data %h", $time,
                 $sampled(retire_data.rob_entry), $sampled(retire_data.w_data),
                 $sampled(exp_head.rob_entry), $sampled(exp_head.w_data));
      end
    end

  a_retire_hold: assert property (@(posedge clk) disable iff (reset)
    (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire_data)))
    else begin
      n_fail++;
      $display("MISMATCH at %0t: retire_data changed while stalled", $time);
    end

  a_after_reset: assert property (@(posedge clk) disable iff (reset)
    (n_pushed == 0) |-> (push_ready && !retire_valid))
    else begin
      n_fail++;
      $display("idle system after reset was not ready or showed a retire at %0t", $time);
    end

  // push at edge n shows retire_valid at edge n+2
  a_latency: assert property (@(posedge clk) disable iff (reset)
    (lat_mode && push_valid && push_ready) |=> (!retire_valid ##1 retire_valid))
    else begin
      n_fail++;
      $display("single push did not reach the retire port two edges later at %0t", $time);
    end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run(string why);
    $display("timeout: %s at %0t", why, $time);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic report_phase(string name, int fails_before);
    $display("phase %s: %0d failures", name, n_fail - fails_before);
  endtask

  task automatic run_phase(int n, int push_pct, int retire_pct);
    int target;
    int cycles;
    target = n_pushed + n;
    cycles = 0;
    while (n_pushed < target) begin
      if (cycles > n * 40 + 200) begin
        abort_run("push phase stalled");
      end
      retire_ready = roll(retire_pct);
      // a pending micro-op is held until taken
      if (!push_valid || push_taken) begin
        push_valid = roll(push_pct);
        if (push_valid) begin
          push_uop = random_uop(next_rob);
        end
      end
      next_cycle();
      cycles++;
    end
    push_valid = 1'b0;
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    push_valid   = 1'b0;
    retire_ready = 1'b1;
    while (exp_q.size() != 0 || retire_valid) begin
      if (cycles > 200) begin
        abort_run("outstanding results did not drain");
      end
      next_cycle();
      cycles++;
    end
  endtask

  initial begin
    int f0;
    int cycles;
    reset        = 1'b1;
    push_valid   = 1'b0;
    push_uop     = '0;
    retire_ready = 1'b0;
    lat_mode     = 1'b0;
    next_rob     = '0;
    exp_head     = '0;
    exp_avail    = 1'b0;
    push_taken   = 1'b0;
    n_pushed     = 0;
    n_retired    = 0;
    n_checks     = 0;
    n_fail       = 0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    f0 = n_fail;
    retire_ready = 1'b1;
    repeat (10) next_cycle();
    report_phase("reset state", f0);

    f0 = n_fail;
    lat_mode = 1'b1;
    repeat (4) begin
      push_valid = 1'b1;
      push_uop   = random_uop(next_rob);
      next_cycle();
      push_valid = 1'b0;
      drain();
    end
    lat_mode = 1'b0;
    report_phase("single push latency", f0);

    f0 = n_fail;
    run_phase(300, 70, 60);
    drain();
    report_phase("random mix", f0);

    f0 = n_fail;
    run_phase(300, 100, 100);
    drain();
    report_phase("full rate burst", f0);

    // back-pressure fills the buffer and then the station
    f0 = n_fail;
    retire_ready = 1'b0;
    cycles = 0;
    while (push_ready) begin
      if (cycles > 100) begin
        abort_run("push_ready never fell under back-pressure");
      end
      if (!push_valid || push_taken) begin
        push_valid = 1'b1;
        push_uop   = random_uop(next_rob);
      end
      next_cycle();
      cycles++;
    end
    push_valid = 1'b0;
    repeat (20) next_cycle();
    n_checks++;
    a_held_count: assert (retire_valid &&
                          n_pushed - n_retired == `RVV_RS_DEPTH + `RVV_RB_DEPTH)
      else begin
        n_fail++;
        $display("MISMATCH at %0t: %0d held, retire_valid %b under back-pressure", $time,
                 n_pushed - n_retired, retire_valid);
      end
    drain();
    report_phase("back-pressure", f0);

    f0 = n_fail;
    run_phase(150, 30, 90);
    drain();
    report_phase("sparse pushes", f0);

    n_checks++;
    a_all_retired: assert (n_pushed == n_retired)
      else begin
        n_fail++;
        $display("MISMATCH at %0t: pushed %0d, retired %0d", $time, n_pushed, n_retired);
      end
    $display("checks: %0d run, %0d failed", n_checks, n_fail);
    if (n_fail == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
